// File: hdl/oflow_settings.svh
//--------------------------------------
// sizes shared by rtl and testbench
// box count must be even and fit a slot
// slot count is 2**FRAME_SLOTS_WIDTH
//--------------------------------------
`ifndef OFLOW_SETTINGS_SVH
`define OFLOW_SETTINGS_SVH

// one box record, four equal coordinates
`define DATA_WIDTH 32
// frames 0..255, wraps
`define TOTAL_FRAME_NUM_WIDTH 8
// fallback depth 1..3
`define NUM_OF_HISTORY_FRAMES_WIDTH 2
// boxes per frame 2..16
`define NUM_OF_BBOX_IN_FRAME_WIDTH 5
// record index inside a slot
`define OFFSET_WIDTH 4
// four frame slots
`define FRAME_SLOTS_WIDTH 2
// apb byte address
`define APB_ADDR_WIDTH 4

`endif

// File: hdl/oflow_bbox_pkg.sv
//--------------------------------------
// types of the stored box data
// bbox_t splits DATA_WIDTH into x y w h
//--------------------------------------
`include "oflow_settings.svh"

package oflow_bbox_pkg;

	// quarter of the record per coordinate
	localparam int COORD_WIDTH = `DATA_WIDTH / 4;

	typedef struct packed {
		logic [COORD_WIDTH-1:0] x;
		logic [COORD_WIDTH-1:0] y;
		logic [COORD_WIDTH-1:0] w;
		logic [COORD_WIDTH-1:0] h;
	} bbox_t;

	// current frame number, modulo 256
	typedef logic [`TOTAL_FRAME_NUM_WIDTH-1:0] frame_num_t;
	// record index inside one slot
	typedef logic [`OFFSET_WIDTH-1:0] offset_t;
	// boxes in one frame
	typedef logic [`NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] bbox_cnt_t;

endpackage

// File: hdl/oflow_ctrl_pkg.sv
//--------------------------------------
// control types of the history buffer
// register map is 32-bit word aligned
//--------------------------------------
`include "oflow_settings.svh"

package oflow_ctrl_pkg;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ_ISSUE,
		ST_READ_WAIT,
		ST_DONE
	} buf_state_t;

	// fallback depth and 1-based history index
	typedef logic [`NUM_OF_HISTORY_FRAMES_WIDTH-1:0] history_cnt_t;

	typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;

	localparam apb_addr_t REG_FRAME_NUM = 'h0;
	localparam apb_addr_t REG_HISTORY   = 'h4;
	localparam apb_addr_t REG_BBOX_CNT  = 'h8;
	localparam apb_addr_t REG_STATUS    = 'hC;

endpackage

// File: hdl/oflow_mem_buffer.sv
//--------------------------------------
// four frame slots of 16 box records
// two lanes, read data one cycle late
// whole array is zeroed by reset
//--------------------------------------
`timescale 1ns/1ps
`include "oflow_settings.svh"

module oflow_mem_buffer (
	input  logic clk,
	input  logic rst,
	input  logic [`FRAME_SLOTS_WIDTH-1:0] slot,
	input  oflow_bbox_pkg::offset_t offset_0,
	input  oflow_bbox_pkg::offset_t offset_1,
	input  logic we,
	input  oflow_bbox_pkg::bbox_t data_in_0,
	input  oflow_bbox_pkg::bbox_t data_in_1,
	output oflow_bbox_pkg::bbox_t data_out_0,
	output oflow_bbox_pkg::bbox_t data_out_1
);
	import oflow_bbox_pkg::*;

	localparam int NUM_SLOTS  = 2 ** `FRAME_SLOTS_WIDTH;
	localparam int SLOT_DEPTH = 2 ** `OFFSET_WIDTH;

	// slot x record
	bbox_t mem [NUM_SLOTS][SLOT_DEPTH];

	// ----------------------------------------
	// write port, both lanes same slot
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			// unwritten history reads back as zero
			for (int s = 0; s < NUM_SLOTS; s++) begin
				for (int o = 0; o < SLOT_DEPTH; o++) begin
					mem[s][o] <= '0;
				end
			end
		end else if (we) begin
			mem[slot][offset_0] <= data_in_0;
			mem[slot][offset_1] <= data_in_1;
		end
	end

	// ----------------------------------------
	// registered read
	// ----------------------------------------
	// address held steady by fsm -> data holds too
	always_ff @(posedge clk) begin
		data_out_0 <= mem[slot][offset_0];
		data_out_1 <= mem[slot][offset_1];
	end

	// the pair from the fsm never collides on one record
	a_lanes_distinct: assert property (@(posedge clk) disable iff (rst)
		we |-> (offset_0 != offset_1));

endmodule

// File: hdl/oflow_fsm_mem_buffer.sv
//--------------------------------------
// sequences write and history-read passes
// config inputs must stay still in a pass
// H = min(history, frame_num), 0 -> no data
//--------------------------------------
`timescale 1ns/1ps
`include "oflow_settings.svh"

module oflow_fsm_mem_buffer (
	input  logic clk,
	input  logic rst,
	input  oflow_bbox_pkg::frame_num_t frame_num,
	input  oflow_ctrl_pkg::history_cnt_t num_of_history_frames,
	input  oflow_bbox_pkg::bbox_cnt_t num_of_bbox_in_frame,
	input  logic start_read,
	input  logic start_write,
	input  logic ready_from_core,
	input  logic read_new_line,
	output logic rnw_st,
	output logic wr_strobe,
	output oflow_bbox_pkg::frame_num_t frame_to_read,
	output oflow_bbox_pkg::offset_t offset_0_read,
	output oflow_bbox_pkg::offset_t offset_1_read,
	output oflow_bbox_pkg::offset_t offset_0_write,
	output oflow_bbox_pkg::offset_t offset_1_write,
	output logic data_out_valid,
	output logic busy,
	output logic done_read,
	output logic done_write,
	output oflow_ctrl_pkg::history_cnt_t counter_of_history_frame_to_interface
);
	import oflow_bbox_pkg::*;
	import oflow_ctrl_pkg::*;

	// one pair covers two records
	localparam int PAIR_WIDTH = `OFFSET_WIDTH - 1;

	buf_state_t state;
	logic [PAIR_WIDTH-1:0] wr_pair;
	logic [PAIR_WIDTH-1:0] rd_pair;
	history_cnt_t hist_cnt;
	history_cnt_t hist_depth;
	logic wr_last;
	logic rd_last_pair;
	logic rd_last_frame;

	// ----------------------------------------
	// addresses and limits
	// ----------------------------------------
	// early frames have fewer frames behind them
	assign hist_depth = (frame_num < frame_num_t'(num_of_history_frames)) ?
		history_cnt_t'(frame_num) : num_of_history_frames;

	// pair k -> records 2k and 2k+1
	assign offset_0_write = {wr_pair, 1'b0};
	assign offset_1_write = {wr_pair, 1'b1};
	assign offset_0_read  = {rd_pair, 1'b0};
	assign offset_1_read  = {rd_pair, 1'b1};

	// frame_num - k, wraps at 256
	assign frame_to_read = frame_num - frame_num_t'(hist_cnt);

	// last pair once odd record + 1 reaches the count
	assign wr_last       = ({1'b0, offset_1_write} + 1'b1) == num_of_bbox_in_frame;
	assign rd_last_pair  = ({1'b0, offset_1_read} + 1'b1) == num_of_bbox_in_frame;
	assign rd_last_frame = (hist_cnt == hist_depth);

	// ----------------------------------------
	// outputs decoded from state
	// ----------------------------------------
	assign wr_strobe      = (state == ST_WRITE) && ready_from_core;
	assign data_out_valid = (state == ST_READ_WAIT);
	assign busy           = (state != ST_IDLE);
	// pass type kept in rnw_st through done
	assign done_write     = (state == ST_DONE) && rnw_st;
	assign done_read      = (state == ST_DONE) && !rnw_st;
	assign counter_of_history_frame_to_interface = hist_cnt;

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= ST_IDLE;
			rnw_st   <= 1'b0;
			wr_pair  <= '0;
			rd_pair  <= '0;
			hist_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// write wins if both starts collide
					if (start_write) begin
						rnw_st  <= 1'b1;
						wr_pair <= '0;
						state   <= ST_WRITE;
					end else if (start_read) begin
						rnw_st  <= 1'b0;
						rd_pair <= '0;
						if (hist_depth == '0) begin
							hist_cnt <= '0;
							state    <= ST_DONE;
						end else begin
							hist_cnt <= history_cnt_t'(1);
							state    <= ST_READ_ISSUE;
						end
					end
				end
				ST_WRITE: begin
					// stall while the core holds back
					if (ready_from_core) begin
						wr_pair <= wr_pair + 1'b1;
						if (wr_last) begin
							state <= ST_DONE;
						end
					end
				end
				ST_READ_ISSUE: begin
					// memory latches the address here
					state <= ST_READ_WAIT;
				end
				ST_READ_WAIT: begin
					// line ends on the metric handshake
					if (read_new_line) begin
						if (!rd_last_pair) begin
							rd_pair <= rd_pair + 1'b1;
							state   <= ST_READ_ISSUE;
						end else if (!rd_last_frame) begin
							rd_pair  <= '0;
							hist_cnt <= hist_cnt + 1'b1;
							state    <= ST_READ_ISSUE;
						end else begin
							state <= ST_DONE;
						end
					end
				end
				ST_DONE: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// a line is never dropped or moved to another frame before the metric takes it
	a_valid_holds: assert property (@(posedge clk) disable iff (rst)
		(data_out_valid && !read_new_line) |=>
			(data_out_valid && $stable(frame_to_read)));

endmodule

// File: hdl/oflow_mem_buffer_wrapper.sv
//--------------------------------------
// fsm plus slot memory
// slot = frame modulo 4, no written check
//--------------------------------------
`timescale 1ns/1ps
`include "oflow_settings.svh"

module oflow_mem_buffer_wrapper (
	input  logic clk,
	input  logic rst,
	input  oflow_bbox_pkg::frame_num_t frame_num,
	input  oflow_ctrl_pkg::history_cnt_t num_of_history_frames,
	input  oflow_bbox_pkg::bbox_cnt_t num_of_bbox_in_frame,
	input  logic start_read,
	input  logic start_write,
	input  logic ready_from_core,
	input  logic read_new_line,
	input  oflow_bbox_pkg::bbox_t data_in_0,
	input  oflow_bbox_pkg::bbox_t data_in_1,
	output logic done_read,
	output logic done_write,
	output logic busy,
	output logic data_out_valid,
	output oflow_bbox_pkg::bbox_t data_out_0,
	output oflow_bbox_pkg::bbox_t data_out_1,
	output oflow_ctrl_pkg::history_cnt_t counter_of_history_frame_to_interface
);
	import oflow_bbox_pkg::*;

	logic rnw_st;
	logic wr_strobe;
	logic we;
	frame_num_t frame_to_read;
	frame_num_t frame_sel;
	offset_t offset_0_read;
	offset_t offset_1_read;
	offset_t offset_0_write;
	offset_t offset_1_write;
	offset_t offset_0;
	offset_t offset_1;

	// ----------------------------------------
	// read / write steering
	// ----------------------------------------
	// write pass -> current frame, read pass -> history frame
	assign frame_sel = rnw_st ? frame_num : frame_to_read;
	assign offset_0  = rnw_st ? offset_0_write : offset_0_read;
	assign offset_1  = rnw_st ? offset_1_write : offset_1_read;
	// only pairs accepted by the core are stored
	assign we        = rnw_st && wr_strobe;

	oflow_mem_buffer u_mem (
		.clk        (clk),
		.rst        (rst),
		.slot       (frame_sel[`FRAME_SLOTS_WIDTH-1:0]),
		.offset_0   (offset_0),
		.offset_1   (offset_1),
		.we         (we),
		.data_in_0  (data_in_0),
		.data_in_1  (data_in_1),
		.data_out_0 (data_out_0),
		.data_out_1 (data_out_1)
	);

	oflow_fsm_mem_buffer u_fsm (
		.clk                   (clk),
		.rst                   (rst),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.num_of_bbox_in_frame  (num_of_bbox_in_frame),
		.start_read            (start_read),
		.start_write           (start_write),
		.ready_from_core       (ready_from_core),
		.read_new_line         (read_new_line),
		.rnw_st                (rnw_st),
		.wr_strobe             (wr_strobe),
		.frame_to_read         (frame_to_read),
		.offset_0_read         (offset_0_read),
		.offset_1_read         (offset_1_read),
		.offset_0_write        (offset_0_write),
		.offset_1_write        (offset_1_write),
		.data_out_valid        (data_out_valid),
		.busy                  (busy),
		.done_read             (done_read),
		.done_write            (done_write),
		.counter_of_history_frame_to_interface (counter_of_history_frame_to_interface)
	);

endmodule

// File: hdl/oflow_mem_apb_regs.sv
//--------------------------------------
// apb config and status, zero wait state
// bad values -> pslverr, register kept
// no writes while a pass is running
//--------------------------------------
`timescale 1ns/1ps
`include "oflow_settings.svh"

module oflow_mem_apb_regs (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`APB_ADDR_WIDTH-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output oflow_bbox_pkg::frame_num_t frame_num,
	output oflow_ctrl_pkg::history_cnt_t num_of_history_frames,
	output oflow_bbox_pkg::bbox_cnt_t num_of_bbox_in_frame,
	input  logic busy,
	input  logic done_write,
	input  oflow_ctrl_pkg::history_cnt_t counter_of_history_frame_to_interface
);
	import oflow_bbox_pkg::*;
	import oflow_ctrl_pkg::*;

	localparam int MAX_BBOX    = 2 ** `OFFSET_WIDTH;
	localparam int MAX_HISTORY = 2 ** `NUM_OF_HISTORY_FRAMES_WIDTH - 1;

	logic wr_access;
	logic rd_status;
	logic bad_history;
	logic bad_bbox_cnt;
	logic wr_error;
	logic done_sticky;

	// ----------------------------------------
	// decode and range checks
	// ----------------------------------------
	assign wr_access = psel && penable && pwrite;
	assign rd_status = psel && penable && !pwrite && (paddr == REG_STATUS);

	assign bad_history  = (pwdata == '0) || (pwdata > MAX_HISTORY);
	// odd, zero or more than a slot holds
	assign bad_bbox_cnt = pwdata[0] || (pwdata == '0) || (pwdata > MAX_BBOX);

	always_comb begin
		case (paddr)
			REG_FRAME_NUM: wr_error = 1'b0;
			REG_HISTORY:   wr_error = bad_history;
			REG_BBOX_CNT:  wr_error = bad_bbox_cnt;
			// status and holes are read-only
			default:       wr_error = 1'b1;
		endcase
	end

	// never stalls
	assign pready  = 1'b1;
	assign pslverr = wr_access && wr_error;

	// ----------------------------------------
	// config registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			frame_num             <= '0;
			num_of_history_frames <= history_cnt_t'(1);
			num_of_bbox_in_frame  <= bbox_cnt_t'(2);
		end else if (wr_access && !wr_error) begin
			case (paddr)
				// frame number wraps, upper bits dropped
				REG_FRAME_NUM: frame_num <= pwdata[`TOTAL_FRAME_NUM_WIDTH-1:0];
				REG_HISTORY: begin
					num_of_history_frames <= pwdata[`NUM_OF_HISTORY_FRAMES_WIDTH-1:0];
				end
				REG_BBOX_CNT: begin
					num_of_bbox_in_frame <= pwdata[`NUM_OF_BBOX_IN_FRAME_WIDTH-1:0];
				end
				default: begin
					frame_num <= frame_num;
				end
			endcase
		end
	end

	// set beats clear when both land together
	always_ff @(posedge clk) begin
		if (rst) begin
			done_sticky <= 1'b0;
		end else if (done_write) begin
			done_sticky <= 1'b1;
		end else if (rd_status) begin
			done_sticky <= 1'b0;
		end
	end

	// ----------------------------------------
	// read mux
	// ----------------------------------------
	always_comb begin
		prdata = '0;
		case (paddr)
			REG_FRAME_NUM: prdata[`TOTAL_FRAME_NUM_WIDTH-1:0] = frame_num;
			REG_HISTORY:   prdata[`NUM_OF_HISTORY_FRAMES_WIDTH-1:0] = num_of_history_frames;
			REG_BBOX_CNT:  prdata[`NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] = num_of_bbox_in_frame;
			REG_STATUS: begin
				prdata[`NUM_OF_HISTORY_FRAMES_WIDTH-1:0] = counter_of_history_frame_to_interface;
				prdata[4] = busy;
				prdata[8] = done_sticky;
			end
			default: prdata = '0;
		endcase
	end

	// config must not move under a running pass
	a_no_cfg_write_busy: assert property (@(posedge clk) disable iff (rst)
		(wr_access && !wr_error) |-> !busy);

endmodule

// File: hdl/oflow_mem_top.sv
//--------------------------------------
// apb registers + history buffer
// core ports pass straight through
//--------------------------------------
`timescale 1ns/1ps
`include "oflow_settings.svh"

module oflow_mem_top (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`APB_ADDR_WIDTH-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic start_read,
	input  logic start_write,
	input  logic ready_from_core,
	input  logic read_new_line,
	input  oflow_bbox_pkg::bbox_t data_in_0,
	input  oflow_bbox_pkg::bbox_t data_in_1,
	output logic done_read,
	output logic done_write,
	output logic data_out_valid,
	output oflow_bbox_pkg::bbox_t data_out_0,
	output oflow_bbox_pkg::bbox_t data_out_1
);
	import oflow_bbox_pkg::*;
	import oflow_ctrl_pkg::*;

	// config from regs, status back
	frame_num_t frame_num;
	history_cnt_t num_of_history_frames;
	bbox_cnt_t num_of_bbox_in_frame;
	logic busy;
	history_cnt_t hist_counter;

	oflow_mem_apb_regs u_regs (
		.clk                   (clk),
		.rst                   (rst),
		.psel                  (psel),
		.penable               (penable),
		.pwrite                (pwrite),
		.paddr                 (paddr),
		.pwdata                (pwdata),
		.prdata                (prdata),
		.pready                (pready),
		.pslverr               (pslverr),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.num_of_bbox_in_frame  (num_of_bbox_in_frame),
		.busy                  (busy),
		.done_write            (done_write),
		.counter_of_history_frame_to_interface (hist_counter)
	);

	oflow_mem_buffer_wrapper u_buf (
		.clk                   (clk),
		.rst                   (rst),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.num_of_bbox_in_frame  (num_of_bbox_in_frame),
		.start_read            (start_read),
		.start_write           (start_write),
		.ready_from_core       (ready_from_core),
		.read_new_line         (read_new_line),
		.data_in_0             (data_in_0),
		.data_in_1             (data_in_1),
		.done_read             (done_read),
		.done_write            (done_write),
		.busy                  (busy),
		.data_out_valid        (data_out_valid),
		.data_out_0            (data_out_0),
		.data_out_1            (data_out_1),
		.counter_of_history_frame_to_interface (hist_counter)
	);

endmodule

// File: testbench/oflow_clk_gen.sv
//----------------------------------------
// 100 ns clock, rst high for 3 edges
// rst drops 10 ns after the third edge
//----------------------------------------
`timescale 1ns/1ps

module oflow_clk_gen (
	output logic clk,
	output logic rst
);
	localparam time PERIOD = 100;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// synchronous reset, seen on three rising edges
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#10 rst = 1'b0;
	end

endmodule

// File: testbench/oflow_mem_tb.sv
//----------------------------------------
// directed tests of the history buffer
// inputs move 10 ns after the rising edge
// outputs sampled mid cycle or after that delay
// first failing check stops the run
//----------------------------------------
`timescale 1ns/1ps
`include "oflow_settings.svh"

module oflow_mem_tb;
	import oflow_bbox_pkg::*;
	import oflow_ctrl_pkg::*;

	localparam int NUM_SLOTS = 2 ** `FRAME_SLOTS_WIDTH;
	localparam int SLOT_DEPTH = 2 ** `OFFSET_WIDTH;
	localparam int TIMEOUT_CYCLES = 200;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_WIDTH-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic start_read;
	logic start_write;
	logic ready_from_core;
	logic read_new_line;
	bbox_t data_in_0;
	bbox_t data_in_1;
	logic done_read;
	logic done_write;
	logic data_out_valid;
	bbox_t data_out_0;
	bbox_t data_out_1;

	// mirror of the slots, updated on every accepted pair
	bbox_t model [NUM_SLOTS][SLOT_DEPTH];
	integer seed;
	string test_name;

	oflow_clk_gen u_clk (
		.clk (clk),
		.rst (rst)
	);

	oflow_mem_top u_dut (
		.clk             (clk),
		.rst             (rst),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.paddr           (paddr),
		.pwdata          (pwdata),
		.prdata          (prdata),
		.pready          (pready),
		.pslverr         (pslverr),
		.start_read      (start_read),
		.start_write     (start_write),
		.ready_from_core (ready_from_core),
		.read_new_line   (read_new_line),
		.data_in_0       (data_in_0),
		.data_in_1       (data_in_1),
		.done_read       (done_read),
		.done_write      (done_write),
		.data_out_valid  (data_out_valid),
		.data_out_0      (data_out_0),
		.data_out_1      (data_out_1)
	);

	// ----------------------------------------
	// timing and compare helpers
	// ----------------------------------------
	// next drive point, 10 ns past the edge
	task automatic tick();
		@(posedge clk);
		#10;
	endtask

	task automatic check_bbox(input string what, input bbox_t exp, input bbox_t act);
		if (exp !== act) begin
			$display("FAIL %s: %s expected %h actual %h", test_name, what, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "box mismatch");
		end
	endtask

	task automatic check_reg(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s: %s expected %h actual %h", test_name, what, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "register mismatch");
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("FAIL %s: %s expected %b actual %b", test_name, what, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic report_timeout(input string sig);
		$display("TIMEOUT in %s: %s never arrived within %0d cycles",
			test_name, sig, TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$fatal(1, "timeout");
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		while (!data_out_valid) begin
			tick();
			n++;
			if (n >= TIMEOUT_CYCLES) report_timeout("data_out_valid");
		end
	endtask

	task automatic wait_done_read();
		int n;
		n = 0;
		while (!done_read) begin
			tick();
			n++;
			if (n >= TIMEOUT_CYCLES) report_timeout("done_read");
		end
	endtask

	task automatic wait_done_write();
		int n;
		n = 0;
		while (!done_write) begin
			tick();
			n++;
			if (n >= TIMEOUT_CYCLES) report_timeout("done_write");
		end
	endtask

	// ----------------------------------------
	// apb driver
	// ----------------------------------------
	// setup then access, pready is tied high
	task automatic apb_access(input apb_addr_t addr, input logic wr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		tick();
		penable = 1'b1;
		// mid access cycle, before the sticky bit can clear
		#40;
		rdata = prdata;
		err   = pslverr;
		check_bit("pready in access phase", 1'b1, pready);
		tick();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input logic [31:0] wdata, input logic exp_err);
		logic [31:0] unused;
		logic err;
		apb_access(addr, 1'b1, wdata, unused, err);
		check_bit("pslverr on write", exp_err, err);
	endtask

	task automatic read_reg(input apb_addr_t addr, output logic [31:0] rdata);
		logic err;
		apb_access(addr, 1'b0, '0, rdata, err);
		check_bit("pslverr on read", 1'b0, err);
	endtask

	// ----------------------------------------
	// write and read passes
	// ----------------------------------------
	task automatic write_frame(input int frame, input int count, input bit random_ready);
		int k;
		int guard;
		bbox_t d0;
		bbox_t d1;
		logic rdy;
		logic [31:0] rnd;
		write_reg(REG_FRAME_NUM, frame, 1'b0);
		write_reg(REG_BBOX_CNT, count, 1'b0);
		start_write = 1'b1;
		tick();
		start_write = 1'b0;
		k = 0;
		guard = 0;
		while (k < count / 2) begin
			d0 = bbox_t'($random(seed));
			d1 = bbox_t'($random(seed));
			rdy = 1'b1;
			if (random_ready) begin
				rnd = $random(seed);
				rdy = rnd[0];
			end
			data_in_0 = d0;
			data_in_1 = d1;
			ready_from_core = rdy;
			tick();
			// stored only when the core was ready at the edge
			if (rdy) begin
				model[frame % NUM_SLOTS][2 * k] = d0;
				model[frame % NUM_SLOTS][2 * k + 1] = d1;
				k++;
			end
			guard++;
			if (guard >= TIMEOUT_CYCLES) report_timeout("acceptance of every write pair");
		end
		ready_from_core = 1'b0;
		wait_done_write();
		tick();
		check_bit("done_write one cycle", 1'b0, done_write);
	endtask

	task automatic read_history(input int frame, input int hist, input int count,
		input bit hold_lines);
		int depth;
		int j;
		int k;
		int slot;
		int hold;
		logic [31:0] status;
		bbox_t exp0;
		bbox_t exp1;
		depth = (frame < hist) ? frame : hist;
		write_reg(REG_FRAME_NUM, frame, 1'b0);
		write_reg(REG_HISTORY, hist, 1'b0);
		write_reg(REG_BBOX_CNT, count, 1'b0);
		start_read = 1'b1;
		tick();
		start_read = 1'b0;
		// newest history frame first
		for (j = 1; j <= depth; j++) begin
			slot = ((frame - j + 256) % 256) % NUM_SLOTS;
			for (k = 0; k < count / 2; k++) begin
				wait_valid();
				exp0 = model[slot][2 * k];
				exp1 = model[slot][2 * k + 1];
				check_bbox("data_out_0", exp0, data_out_0);
				check_bbox("data_out_1", exp1, data_out_1);
				if (hold_lines) begin
					read_reg(REG_STATUS, status);
					check_reg("history counter mid line", j, status & 32'h3);
					check_bit("busy mid line", 1'b1, status[4]);
					hold = 1 + ($unsigned($random(seed)) % 4);
					repeat (hold) begin
						tick();
						check_bit("valid held", 1'b1, data_out_valid);
						check_bbox("data_out_0 held", exp0, data_out_0);
						check_bbox("data_out_1 held", exp1, data_out_1);
					end
				end
				read_new_line = 1'b1;
				tick();
				read_new_line = 1'b0;
				check_bit("valid drops after line", 1'b0, data_out_valid);
			end
		end
		wait_done_read();
		tick();
		check_bit("done_read one cycle", 1'b0, done_read);
		read_reg(REG_STATUS, status);
		check_reg("history counter after pass", depth, status & 32'h3);
		check_bit("busy after pass", 1'b0, status[4]);
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic register_access();
		logic [31:0] rd;
		test_name = "register_access";
		read_reg(REG_FRAME_NUM, rd);
		check_reg("frame reset", 32'd0, rd);
		read_reg(REG_HISTORY, rd);
		check_reg("history reset", 32'd1, rd);
		read_reg(REG_BBOX_CNT, rd);
		check_reg("bbox count reset", 32'd2, rd);
		read_reg(REG_STATUS, rd);
		check_reg("status reset", 32'd0, rd);
		write_reg(REG_FRAME_NUM, 32'd5, 1'b0);
		write_reg(REG_HISTORY, 32'd3, 1'b0);
		write_reg(REG_BBOX_CNT, 32'd8, 1'b0);
		read_reg(REG_FRAME_NUM, rd);
		check_reg("frame written", 32'd5, rd);
		// rejected values leave the old contents
		write_reg(REG_HISTORY, 32'd0, 1'b1);
		read_reg(REG_HISTORY, rd);
		check_reg("history kept", 32'd3, rd);
		write_reg(REG_BBOX_CNT, 32'd3, 1'b1);
		read_reg(REG_BBOX_CNT, rd);
		check_reg("bbox count kept", 32'd8, rd);
		write_reg(REG_STATUS, 32'h1ff, 1'b1);
		read_reg(REG_STATUS, rd);
		check_reg("status after write", 32'd0, rd);
		read_reg(REG_FRAME_NUM, rd);
		check_reg("frame kept after status write", 32'd5, rd);
	endtask

	task automatic single_history_read();
		test_name = "single_history_read";
		write_reg(REG_HISTORY, 32'd1, 1'b0);
		write_frame(0, 8, 1'b0);
		write_frame(1, 8, 1'b0);
		read_history(2, 1, 8, 1'b0);
	endtask

	task automatic multi_frame_fallback();
		int f;
		test_name = "multi_frame_fallback";
		// frame 4 lands on the slot of frame 0
		for (f = 0; f <= 4; f++) begin
			write_frame(f, 8, 1'b0);
		end
		read_history(4, 3, 8, 1'b0);
	endtask

	task automatic read_backpressure();
		test_name = "read_backpressure";
		read_history(4, 3, 8, 1'b1);
	endtask

	task automatic write_backpressure();
		logic [31:0] rd;
		test_name = "write_backpressure";
		// clear sticky bit left by earlier writes
		read_reg(REG_STATUS, rd);
		write_frame(5, 16, 1'b1);
		read_reg(REG_STATUS, rd);
		check_bit("done_write sticky set", 1'b1, rd[8]);
		read_reg(REG_STATUS, rd);
		check_bit("done_write sticky cleared", 1'b0, rd[8]);
		read_history(6, 1, 16, 1'b0);
	endtask

	task automatic frame_zero_read();
		int n;
		logic [31:0] rd;
		test_name = "frame_zero_read";
		write_reg(REG_FRAME_NUM, 32'd0, 1'b0);
		write_reg(REG_HISTORY, 32'd3, 1'b0);
		write_reg(REG_BBOX_CNT, 32'd8, 1'b0);
		start_read = 1'b1;
		tick();
		start_read = 1'b0;
		n = 0;
		while (!done_read) begin
			check_bit("no valid before done", 1'b0, data_out_valid);
			tick();
			n++;
			if (n >= TIMEOUT_CYCLES) report_timeout("done_read");
		end
		check_bit("no valid at done", 1'b0, data_out_valid);
		tick();
		check_bit("done_read one cycle", 1'b0, done_read);
		check_bit("no valid after done", 1'b0, data_out_valid);
		read_reg(REG_STATUS, rd);
		check_reg("history counter", 32'd0, rd & 32'h3);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int n;
		seed = 3479;
		test_name = "reset";
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		start_read = 1'b0;
		start_write = 1'b0;
		ready_from_core = 1'b0;
		read_new_line = 1'b0;
		data_in_0 = '0;
		data_in_1 = '0;
		// memory comes out of reset all zero
		for (int s = 0; s < NUM_SLOTS; s++) begin
			for (int o = 0; o < SLOT_DEPTH; o++) begin
				model[s][o] = '0;
			end
		end
		n = 0;
		do begin
			tick();
			n++;
			if (n >= TIMEOUT_CYCLES) report_timeout("reset release");
		end while (rst);
		register_access();
		single_history_read();
		multi_frame_fallback();
		read_backpressure();
		write_backpressure();
		frame_zero_read();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hdl
hdl/oflow_bbox_pkg.sv
hdl/oflow_ctrl_pkg.sv
hdl/oflow_mem_buffer.sv
hdl/oflow_fsm_mem_buffer.sv
hdl/oflow_mem_buffer_wrapper.sv
hdl/oflow_mem_apb_regs.sv
hdl/oflow_mem_top.sv
testbench/oflow_clk_gen.sv
testbench/oflow_mem_tb.sv

// File: Bender.yml
package:
  name: oflow_mem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/oflow_bbox_pkg.sv
      - hdl/oflow_ctrl_pkg.sv
      - hdl/oflow_mem_buffer.sv
      - hdl/oflow_fsm_mem_buffer.sv
      - hdl/oflow_mem_buffer_wrapper.sv
      - hdl/oflow_mem_apb_regs.sv
      - hdl/oflow_mem_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/oflow_clk_gen.sv
      - testbench/oflow_mem_tb.sv
